// File: Makefile
VERILATOR = verilator
VFLAGS    = --timing
TOP       = tbControlInterface
FILELIST  = list.f
OBJDIR    = obj_dir
PASS_TEXT = Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR) -o $(TOP)
	@out="$$(./$(OBJDIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

// File: hdl/cmdSequencer.sv
`timescale 1ns/1ns
`include "ctrlDefs_defs.svh"

module cmdSequencer
(
    input  logic              CLK,
    input  logic              RESET,
    input  ctrlPkg::cmdWord_t cmdFifoQ,
    input  logic              cmdFifoEmpty,
    output logic              cmdFifoRdReq,
    output logic              memWe,
    output ctrlPkg::memAddr_t memAddr,
    output ctrlPkg::memData_t memDin,
    input  ctrlPkg::memData_t memDout,
    input  logic              pulseBusy,
    input  logic              progFull,
    output logic              regWrite,
    output ctrlPkg::regAddr_t regAddr,
    output ctrlPkg::regData_t regWrData,
    input  ctrlPkg::regData_t regRdData,
    output ctrlPkg::memData_t replyData,
    output logic              replyWrite
);
    import ctrlPkg::*;

    seqState_t state;
    cmdWord_t  cmdLatch;     // word popped in WAIT_CMD
    regData_t  memCount;     // reg 16
    memAddr_t  addrReg;      // regs 17/18
    regData_t  dataLo;       // reg 19
    regData_t  burstCnt;     // words left in a burst

    logic      isRead;
    regAddr_t  cmdAddr;
    regData_t  cmdData;

    // command fields
    assign isRead  = cmdLatch[`CMD_WIDTH-1];
    assign cmdAddr = cmdLatch[`REG_DATA_WIDTH +: `REG_ADDR_WIDTH];
    assign cmdData = cmdLatch[`REG_DATA_WIDTH-1:0];

    // fwft pop, held off while a pulse is running
    assign cmdFifoRdReq = (state == WAIT_CMD) && !cmdFifoEmpty && !pulseBusy;

    // memory port
    assign memWe   = (state == MEM_ADV);         // one cycle strobe
    assign memAddr = addrReg;
    assign memDin  = {cmdData, dataLo};          // command data on top

    // register bank sees the latched fields directly
    assign regAddr   = cmdAddr;
    assign regWrData = cmdData;

    ////////////////////////////////////////////////////////////////////////////
    // decode: strobes and reply data
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        regWrite   = 1'b0;
        replyWrite = 1'b0;
        replyData  = memData_t'(regRdData);      // status / config / bad read
        case (state)
            INTERPRET_CMD:
            begin
                if (isRead)
                begin
                    replyWrite = 1'b1;
                    case (cmdAddr)
                        `ADDR_MEM_COUNT: replyData = memData_t'(memCount);
                        `ADDR_ADDR_LO:   replyData = memData_t'(addrReg[`REG_DATA_WIDTH-1:0]);
                        `ADDR_ADDR_HI:
                            replyData = memData_t'(addrReg[`MEM_WIDTH-1:`REG_DATA_WIDTH]);
                        `ADDR_DATA_LO:   replyData = memData_t'(dataLo);
                        `ADDR_MEM_DATA:  replyWrite = 1'b0;   // burst handles it
                        default:         replyData = memData_t'(regRdData);
                    endcase
                end
                else
                begin
                    // memory group is kept here, everything else goes to the bank
                    case (cmdAddr)
                        `ADDR_MEM_COUNT, `ADDR_ADDR_LO, `ADDR_ADDR_HI,
                        `ADDR_DATA_LO, `ADDR_MEM_DATA: regWrite = 1'b0;
                        default:                       regWrite = 1'b1;
                    endcase
                end
            end
            MEM_RD_CNT:
            begin
                if (burstCnt != '0 && !progFull)
                begin
                    replyWrite = 1'b1;               // memDout is same-cycle
                    replyData  = memDout;
                end
            end
            default:
            begin
                replyWrite = 1'b0;
            end
        endcase
    end

    // command word capture on pop
    always_ff @(posedge CLK)
    begin
        if (cmdFifoRdReq)
            cmdLatch <= cmdFifoQ;
    end

    ////////////////////////////////////////////////////////////////////////////
    // state machine and memory registers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or posedge RESET)
    begin
        if (RESET)
        begin
            state    <= WAIT_CMD;
            memCount <= regData_t'(1);           // at least one word per burst
            addrReg  <= '0;
            dataLo   <= '0;
            burstCnt <= '0;
        end
        else
        begin
            case (state)
                WAIT_CMD:
                begin
                    if (cmdFifoRdReq)
                        state <= INTERPRET_CMD;
                end
                INTERPRET_CMD:
                begin
                    state <= WAIT_CMD;
                    if (isRead)
                    begin
                        if (cmdAddr == `ADDR_MEM_DATA)
                        begin
                            burstCnt <= memCount;
                            state    <= MEM_RD_CNT;
                        end
                    end
                    else
                    begin
                        case (cmdAddr)
                            `ADDR_MEM_COUNT: memCount <= cmdData;
                            `ADDR_ADDR_LO:   addrReg[`REG_DATA_WIDTH-1:0] <= cmdData;
                            `ADDR_ADDR_HI:   addrReg[`MEM_WIDTH-1:`REG_DATA_WIDTH] <= cmdData;
                            `ADDR_DATA_LO:   dataLo <= cmdData;
                            `ADDR_MEM_DATA:  state <= MEM_ADV;    // strobe next cycle
                            default:         state <= WAIT_CMD;
                        endcase
                    end
                end
                MEM_ADV:
                begin
                    addrReg <= addrReg + memAddr_t'(1);   // after the strobe
                    state   <= WAIT_CMD;
                end
                MEM_RD_CNT:
                begin
                    if (burstCnt == '0)
                        state <= WAIT_CMD;               // done, zero count sends nothing
                    else if (!progFull)
                    begin
                        addrReg  <= addrReg + memAddr_t'(1);
                        burstCnt <= burstCnt - regData_t'(1);
                    end
                end
                default:
                begin
                    state <= WAIT_CMD;
                end
            endcase
        end
    end

endmodule

// File: hdl/controlInterface.sv
`timescale 1ns/1ns
`include "ctrlDefs_defs.svh"

module controlInterface
(
    input  logic                                      CLK,
    input  logic                                      RESET,
    // command fifo, fwft
    input  ctrlPkg::cmdWord_t                         cmdFifoQ,
    input  logic                                      cmdFifoEmpty,
    output logic                                      cmdFifoRdReq,
    // reply fifo, fwft
    output ctrlPkg::memData_t                         fifoQ,
    output logic                                      fifoEmpty,
    input  logic                                      fifoRdReq,
    // register io
    output logic [`CONFIG_COUNT*`REG_DATA_WIDTH-1:0]  configReg,
    output ctrlPkg::regData_t                         pulseReg,
    input  logic [`STATUS_COUNT*`REG_DATA_WIDTH-1:0]  statusReg,
    // memory port
    output logic                                      memWe,
    output ctrlPkg::memAddr_t                         memAddr,
    output ctrlPkg::memData_t                         memDin,
    input  ctrlPkg::memData_t                         memDout
);
    import ctrlPkg::*;

    // sequencer <-> register bank
    logic     regWrite;
    regAddr_t regAddr;
    regData_t regWrData;
    regData_t regRdData;
    logic     pulseBusy;     // holds off new commands

    // sequencer -> reply fifo
    memData_t replyData;
    logic     replyWrite;
    logic     progFull;      // stalls bursts

    cmdSequencer sequencer
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .cmdFifoQ     (cmdFifoQ),
        .cmdFifoEmpty (cmdFifoEmpty),
        .cmdFifoRdReq (cmdFifoRdReq),
        .memWe        (memWe),
        .memAddr      (memAddr),
        .memDin       (memDin),
        .memDout      (memDout),
        .pulseBusy    (pulseBusy),
        .progFull     (progFull),
        .regWrite     (regWrite),
        .regAddr      (regAddr),
        .regWrData    (regWrData),
        .regRdData    (regRdData),
        .replyData    (replyData),
        .replyWrite   (replyWrite)
    );

    regBank registers
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .regWrite  (regWrite),
        .regAddr   (regAddr),
        .regWrData (regWrData),
        .regRdData (regRdData),
        .pulseBusy (pulseBusy),
        .configReg (configReg),
        .pulseReg  (pulseReg),
        .statusReg (statusReg)
    );

    replyFifo #(.DEPTH(`REPLY_DEPTH)) replies
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wrData   (replyData),
        .wrEn     (replyWrite),
        .rdEn     (fifoRdReq),
        .rdData   (fifoQ),
        .empty    (fifoEmpty),
        .progFull (progFull)
    );

endmodule

// File: hdl/ctrlPkg.sv
`include "ctrlDefs_defs.svh"

package ctrlPkg;

    // plain vectors, one per meaningful width
    typedef logic [`CMD_WIDTH-1:0]      cmdWord_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;
    typedef logic [`REG_DATA_WIDTH-1:0] regData_t;
    typedef logic [`MEM_WIDTH-1:0]      memAddr_t;
    typedef logic [`MEM_WIDTH-1:0]      memData_t;   // also a reply word

    // command sequencer states
    typedef enum logic [1:0]
    {
        WAIT_CMD,        // idle, pop when a word shows up
        INTERPRET_CMD,   // decode the latched word
        MEM_ADV,         // memory write strobe, then bump address
        MEM_RD_CNT       // burst memory words into the reply fifo
    } seqState_t;

endpackage

// File: hdl/regBank.sv
`timescale 1ns/1ns
`include "ctrlDefs_defs.svh"

module regBank
(
    input  logic                                      CLK,
    input  logic                                      RESET,
    input  logic                                      regWrite,
    input  ctrlPkg::regAddr_t                         regAddr,
    input  ctrlPkg::regData_t                         regWrData,
    output ctrlPkg::regData_t                         regRdData,
    output logic                                      pulseBusy,
    output logic [`CONFIG_COUNT*`REG_DATA_WIDTH-1:0]  configReg,
    output ctrlPkg::regData_t                         pulseReg,
    input  logic [`STATUS_COUNT*`REG_DATA_WIDTH-1:0]  statusReg
);
    import ctrlPkg::*;

    localparam regAddr_t CfgFirst  = regAddr_t'(`CONFIG_BASE);
    localparam regAddr_t CfgLast   = regAddr_t'(`CONFIG_BASE + `CONFIG_COUNT - 1);
    localparam regAddr_t StatLast  = regAddr_t'(`STATUS_COUNT - 1);
    localparam regAddr_t PulseAddr = regAddr_t'(`ADDR_PULSE);
    localparam int       PulseW    = $clog2(`PULSE_CYCLES + 1);

    logic              inConfig;
    logic              inStatus;
    regAddr_t          cfgIdx;       // offset into the config block
    logic [PulseW-1:0] pulseCnt;     // cycles the pulse is still held

    assign inConfig  = (regAddr >= CfgFirst) && (regAddr <= CfgLast);
    assign inStatus  = (regAddr <= StatLast);
    assign cfgIdx    = regAddr - CfgFirst;
    assign pulseBusy = (pulseCnt != '0);

    ////////////////////////////////////////////////////////////////////////////
    // config and pulse registers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or posedge RESET)
    begin
        if (RESET)
        begin
            configReg <= '1;             // all ones out of reset
            pulseReg  <= '0;
            pulseCnt  <= '0;
        end
        else
        begin
            if (regWrite && inConfig)
                configReg[cfgIdx*`REG_DATA_WIDTH +: `REG_DATA_WIDTH] <= regWrData;

            if (regWrite && regAddr == PulseAddr)
            begin
                pulseReg <= regWrData;
                pulseCnt <= PulseW'(`PULSE_CYCLES);
            end
            else if (pulseBusy)
            begin
                pulseCnt <= pulseCnt - PulseW'(1);
                if (pulseCnt == PulseW'(1))
                    pulseReg <= '0;      // last held cycle
            end
        end
    end

    // read mux, status below config, anything else is a bad read
    always_comb
    begin
        if (inStatus)
            regRdData = statusReg[regAddr*`REG_DATA_WIDTH +: `REG_DATA_WIDTH];
        else if (inConfig)
            regRdData = configReg[cfgIdx*`REG_DATA_WIDTH +: `REG_DATA_WIDTH];
        else
            regRdData = `BAD_READ_VALUE;
    end

endmodule

// File: hdl/replyFifo.sv
`timescale 1ns/1ns
`include "ctrlDefs_defs.svh"

module replyFifo
#(
    parameter int DEPTH = `REPLY_DEPTH    // power of two
)
(
    input  logic              CLK,
    input  logic              RESET,
    input  ctrlPkg::memData_t wrData,
    input  logic              wrEn,
    input  logic              rdEn,
    output ctrlPkg::memData_t rdData,
    output logic              empty,
    output logic              progFull
);
    import ctrlPkg::*;

    localparam int           AW     = $clog2(DEPTH);
    localparam logic [AW:0]  Depth  = (AW+1)'(DEPTH);
    localparam logic [AW:0]  Margin = (AW+1)'(`REPLY_MARGIN);

    memData_t        mem [DEPTH];
    logic [AW-1:0]   wrPtr;
    logic [AW-1:0]   rdPtr;
    logic [AW:0]     count;          // occupancy, one bit wider than pointers
    logic            doWr;
    logic            doRd;

    assign empty    = (count == '0);
    assign progFull = (Depth - count) < Margin;
    assign doWr     = wrEn && (count != Depth);   // drop on full
    assign doRd     = rdEn && !empty;
    assign rdData   = mem[rdPtr];                 // fwft head

    // storage
    always_ff @(posedge CLK)
    begin
        if (doWr)
            mem[wrPtr] <= wrData;
    end

    ////////////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or posedge RESET)
    begin
        if (RESET)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (doWr)
                wrPtr <= wrPtr + AW'(1);    // wraps at DEPTH
            if (doRd)
                rdPtr <= rdPtr + AW'(1);
            case ({doWr, doRd})
                2'b10:   count <= count + (AW+1)'(1);
                2'b01:   count <= count - (AW+1)'(1);
                default: count <= count;    // both or neither
            endcase
        end
    end

endmodule

// File: include/ctrlDefs_defs.svh
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// command word layout: rw flag on top, address, then data in the low half
`define CMD_WIDTH       32
`define REG_ADDR_WIDTH  12
`define REG_DATA_WIDTH  16
`define MEM_WIDTH       32     // memory address and data

////////////////////////////////////////////////////////////////////////////
// register map
////////////////////////////////////////////////////////////////////////////
`define CONFIG_COUNT    40     // config regs at CONFIG_BASE and up
`define STATUS_COUNT    11     // read only status at 0 and up
`define CONFIG_BASE     32

`define ADDR_PULSE      11
`define ADDR_MEM_COUNT  16     // burst word count
`define ADDR_ADDR_LO    17
`define ADDR_ADDR_HI    18
`define ADDR_DATA_LO    19     // low half of the next memory word
`define ADDR_MEM_DATA   20     // write = store word, read = burst

`define BAD_READ_VALUE  16'hFFFF

// pulse register hold time in cycles
`define PULSE_CYCLES    3

// reply fifo
`define REPLY_DEPTH     512
`define REPLY_MARGIN    4      // prog full below this many free slots

`endif

// File: list.f
+incdir+include
hdl/ctrlPkg.sv
hdl/replyFifo.sv
hdl/regBank.sv
hdl/cmdSequencer.sv
hdl/controlInterface.sv
testbench/clockGen.sv
testbench/tbControlInterface.sv

// File: testbench/clockGen.sv
`timescale 1ns/1ns

module clockGen
(
    output logic CLK,
    output logic RESET
);
    localparam int HalfPeriod  = 2;    // 4 ns clock
    localparam int ResetCycles = 3;

    initial
    begin
        CLK = 1'b0;
        forever #HalfPeriod CLK = ~CLK;
    end

    initial
    begin
        RESET = 1'b1;
        repeat (ResetCycles) @(posedge CLK);
        RESET <= 1'b0;                 // released on a rising edge
    end

endmodule

// File: testbench/tbControlInterface.sv
`timescale 1ns/1ns
`include "ctrlDefs_defs.svh"

module tbControlInterface;
    import ctrlPkg::*;

    localparam int TimeoutCycles = 6000;   // tests need about 3700 cycles, mostly the fifo fill
    localparam int MemWords      = 256;    // model decodes the low address byte
    localparam int FillReads     = 500;    // replies parked before the burst

    logic                                     CLK;
    logic                                     RESET;
    cmdWord_t                                 cmdFifoQ     = '0;
    logic                                     cmdFifoEmpty = 1'b1;
    logic                                     cmdFifoRdReq;
    memData_t                                 fifoQ;
    logic                                     fifoEmpty;
    logic                                     fifoRdReq    = 1'b0;
    logic [`CONFIG_COUNT*`REG_DATA_WIDTH-1:0] configReg;
    regData_t                                 pulseReg;
    logic [`STATUS_COUNT*`REG_DATA_WIDTH-1:0] statusReg;
    logic                                     memWe;
    memAddr_t                                 memAddr;
    memData_t                                 memDin;
    memData_t                                 memDout;

    cmdWord_t  cmdQueue [$];               // host side command fifo
    memData_t  expQueue [$];               // replies still owed
    bit [31:0] memArr [MemWords];
    bit        memValid [MemWords];        // written since start

    // shadow copies, updated as commands are queued
    regData_t  cfgShadow [`CONFIG_COUNT];
    regData_t  statusShadow [`STATUS_COUNT];
    regData_t  countShadow;
    memAddr_t  addrShadow;
    regData_t  dataLoShadow;
    memData_t  memShadow [memAddr_t];

    logic [31:0] rngState = 32'hcb05;
    string       curTest = "";
    int          errors;
    int          checks;
    int          tests;
    int          testErrStart;
    int          drainEvery = 1;           // host reads every n-th cycle, 0 stops it
    int          drainPhase;
    int          cycleCount;

    clockGen clocks (.CLK(CLK), .RESET(RESET));

    controlInterface UUT
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .cmdFifoQ     (cmdFifoQ),
        .cmdFifoEmpty (cmdFifoEmpty),
        .cmdFifoRdReq (cmdFifoRdReq),
        .fifoQ        (fifoQ),
        .fifoEmpty    (fifoEmpty),
        .fifoRdReq    (fifoRdReq),
        .configReg    (configReg),
        .pulseReg     (pulseReg),
        .statusReg    (statusReg),
        .memWe        (memWe),
        .memAddr      (memAddr),
        .memDin       (memDin),
        .memDout      (memDout)
    );

    // xorshift32
    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // contents of never written memory, mixes every address bit
    function automatic memData_t fillWord(input memAddr_t a);
        return (a * 32'h9e3779b9) ^ 32'h0badf00d;
    endfunction

    function automatic memData_t shadowWord(input memAddr_t a);
        return memShadow.exists(a) ? memShadow[a] : fillWord(a);
    endfunction

    // reply for any single read, straight from the register map rules
    function automatic memData_t expectedReply(input regAddr_t a);
        int       idx;
        memData_t result;
        idx = int'(a);
        if (idx < `STATUS_COUNT)
            result = memData_t'(statusShadow[idx]);
        else if (idx >= `CONFIG_BASE && idx < `CONFIG_BASE + `CONFIG_COUNT)
            result = memData_t'(cfgShadow[idx - `CONFIG_BASE]);
        else if (idx == `ADDR_MEM_COUNT)
            result = memData_t'(countShadow);
        else if (idx == `ADDR_ADDR_LO)
            result = memData_t'(addrShadow[15:0]);
        else if (idx == `ADDR_ADDR_HI)
            result = memData_t'(addrShadow[31:16]);
        else if (idx == `ADDR_DATA_LO)
            result = memData_t'(dataLoShadow);
        else
            result = memData_t'(`BAD_READ_VALUE);   // unknown address
        return result;
    endfunction

    task automatic check(input string what, input memData_t expected, input memData_t actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("CHECK FAILED %s (%s): expected %h, actual %h",
                     curTest, what, expected, actual);
        end
    endtask

    task automatic writeReg(input int addr, input regData_t data);
        cmdQueue.push_back({1'b0, 3'b000, regAddr_t'(addr), data});
        if (addr >= `CONFIG_BASE && addr < `CONFIG_BASE + `CONFIG_COUNT)
            cfgShadow[addr - `CONFIG_BASE] = data;
        else if (addr == `ADDR_MEM_COUNT)
            countShadow = data;
        else if (addr == `ADDR_ADDR_LO)
            addrShadow[15:0] = data;
        else if (addr == `ADDR_ADDR_HI)
            addrShadow[31:16] = data;
        else if (addr == `ADDR_DATA_LO)
            dataLoShadow = data;
        else if (addr == `ADDR_MEM_DATA)
        begin
            memShadow[addrShadow] = {data, dataLoShadow};   // command data on top
            addrShadow = addrShadow + 1;
        end
    endtask

    task automatic readReg(input int addr);
        cmdQueue.push_back({1'b1, 3'b000, regAddr_t'(addr), 16'h0000});
        if (addr == `ADDR_MEM_DATA)
        begin
            for (int i = 0; i < int'(countShadow); i++)    // burst, none for zero
            begin
                expQueue.push_back(shadowWord(addrShadow));
                addrShadow = addrShadow + 1;
            end
        end
        else
            expQueue.push_back(expectedReply(regAddr_t'(addr)));
    endtask

    // all commands taken and all replies seen, then the last write settles
    task automatic waitIdle();
        while (cmdQueue.size() != 0 || expQueue.size() != 0)
            @(posedge CLK);
        repeat (3) @(posedge CLK);     // interpret, strobe, address bump
    endtask

    task automatic startTest(input string name);
        curTest = name;
        testErrStart = errors;
    endtask

    task automatic finishTest();
        waitIdle();
        tests++;
        $display("test %s: %s", curTest, (errors == testErrStart) ? "ok" : "FAILED");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // host side models
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge CLK)
    begin
        if (cmdFifoRdReq && cmdQueue.size() != 0)
            void'(cmdQueue.pop_front());            // fwft pop
        cmdFifoEmpty <= (cmdQueue.size() == 0);
        cmdFifoQ     <= (cmdQueue.size() != 0) ? cmdQueue[0] : '0;
    end

    always @(posedge CLK)
    begin
        if (memWe)
        begin
            memArr[memAddr[7:0]]   <= memDin;
            memValid[memAddr[7:0]] <= 1'b1;
        end
    end

    assign memDout = memValid[memAddr[7:0]] ? memArr[memAddr[7:0]] : fillWord(memAddr);

    // reply drain and compare
    always @(posedge CLK)
    begin
        memData_t want;
        if (fifoRdReq && !fifoEmpty)              // word taken at this edge
        begin
            if (expQueue.size() == 0)
            begin
                errors++;
                $display("reply FIFO returned %h while no reply was expected in test %s",
                         fifoQ, curTest);
            end
            else
            begin
                want = expQueue.pop_front();
                check("reply", want, fifoQ);
            end
        end
        if (drainEvery > 0)
            drainPhase = (drainPhase + 1) % drainEvery;
        fifoRdReq <= (drainEvery > 0) && (drainPhase == 0);
    end

    always @(posedge CLK)
    begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles)
        begin
            $display("timeout: run stopped after %0d cycles", cycleCount);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////
    initial
    begin
        logic [`STATUS_COUNT*`REG_DATA_WIDTH-1:0] statusVec;
        logic [31:0] r;
        int          addr;
        int          held;
        int          popsInPulse;
        regData_t    pulseVal;

        for (int i = 0; i < `STATUS_COUNT; i++)
        begin
            r = nextRandom();
            statusShadow[i] = r[15:0];
            statusVec[i*`REG_DATA_WIDTH +: `REG_DATA_WIDTH] = r[15:0];
        end
        statusReg <= statusVec;                    // constant for the whole run
        foreach (cfgShadow[i])
            cfgShadow[i] = '1;
        countShadow  = regData_t'(1);
        addrShadow   = '0;
        dataLoShadow = '0;

        @(negedge RESET);
        @(posedge CLK);

        startTest("reset");
        check("fifoEmpty", 1, memData_t'(fifoEmpty));
        check("pulseReg", 0, memData_t'(pulseReg));
        for (int a = `CONFIG_BASE; a < `CONFIG_BASE + `CONFIG_COUNT; a++)
            readReg(a);
        readReg(`ADDR_MEM_COUNT);
        readReg(`ADDR_ADDR_LO);
        readReg(`ADDR_ADDR_HI);
        finishTest();

        startTest("config");
        for (int n = 0; n < 16; n++)
        begin
            r = nextRandom();
            addr = `CONFIG_BASE + (int'(r[31:16]) % `CONFIG_COUNT);
            writeReg(addr, r[15:0]);
        end
        for (int a = `CONFIG_BASE; a < `CONFIG_BASE + `CONFIG_COUNT; a++)
            readReg(a);
        waitIdle();
        for (int i = 0; i < `CONFIG_COUNT; i++)
            check("configReg", memData_t'(cfgShadow[i]),
                  memData_t'(configReg[i*`REG_DATA_WIDTH +: `REG_DATA_WIDTH]));
        finishTest();

        startTest("status");
        for (int a = 0; a < `STATUS_COUNT; a++)
            readReg(a);
        writeReg(13, 16'h1234);                    // unused, ignored
        writeReg(100, 16'h4321);
        writeReg(4095, 16'h0000);
        readReg(12);
        readReg(13);
        readReg(72);
        readReg(100);
        readReg(4095);
        for (int a = `CONFIG_BASE; a < `CONFIG_BASE + `CONFIG_COUNT; a++)
            readReg(a);
        finishTest();

        startTest("pulse");
        r = nextRandom();
        pulseVal = r[15:0] | 16'h0001;             // never zero
        writeReg(`ADDR_PULSE, pulseVal);
        readReg(`CONFIG_BASE);                     // held back until the pulse ends
        while (pulseReg !== pulseVal)
            @(posedge CLK);
        held = 0;
        popsInPulse = 0;
        while (pulseReg === pulseVal)
        begin
            held++;
            if (cmdFifoRdReq)
                popsInPulse++;
            @(posedge CLK);
        end
        check("held cycles", `PULSE_CYCLES, held);
        check("after hold", 0, memData_t'(pulseReg));
        check("pops while held", 0, popsInPulse);
        finishTest();

        startTest("memory");
        writeReg(`ADDR_ADDR_LO, 16'h0040);
        writeReg(`ADDR_ADDR_HI, 16'h0000);
        for (int n = 0; n < 6; n++)
        begin
            r = nextRandom();
            writeReg(`ADDR_DATA_LO, r[15:0]);
            writeReg(`ADDR_MEM_DATA, r[31:16]);
        end
        waitIdle();
        for (int a = 'h40; a < 'h46; a++)
            check("memory word", shadowWord(memAddr_t'(a)), memArr[a]);
        writeReg(`ADDR_ADDR_LO, 16'h0040);         // back to the start
        writeReg(`ADDR_MEM_COUNT, 16'd20);
        // host stops reading so the burst runs into prog full
        drainEvery = 0;
        for (int n = 0; n < FillReads; n++)
            readReg(`CONFIG_BASE);
        readReg(`ADDR_MEM_DATA);
        while (cmdQueue.size() != 0)
            @(posedge CLK);
        repeat (20) @(posedge CLK);                // burst stalls on a full fifo
        drainEvery = 4;                            // slow host
        waitIdle();
        drainEvery = 1;
        readReg(`ADDR_ADDR_LO);                    // start plus 20
        readReg(`ADDR_ADDR_HI);
        writeReg(`ADDR_MEM_COUNT, 16'd0);
        readReg(`ADDR_MEM_DATA);                   // zero count, no reply
        readReg(`ADDR_MEM_COUNT);
        finishTest();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
